//--- rtl/spi_pkg.sv
// SPI subsystem shared definitions
// Timing constants, host command and response records, master FSM
// states and the power-up image of the slave exchange buffer

package spi_pkg;

	// ************************************************************
	// Timing and sizing
	// ************************************************************

	// System clocks per sck half period
	// Must exceed the three-cycle slave synchronizer delay
	localparam int sck_half = 4;

	// Width of the half-period counters
	localparam int sck_cnt_w = $clog2(sck_half);

	// Slave buffer geometry, pointer wraps at the depth
	localparam int buf_depth = 8;
	localparam int ptr_w = 3;

	// Buffer contents after reset, entry 0 holds 0x11
	localparam logic [buf_depth-1:0][7:0] buf_init = {
		8'h88, 8'h77, 8'h66, 8'h55,
		8'h44, 8'h33, 8'h22, 8'h11
	};

	// ************************************************************
	// Host interface records
	// ************************************************************

	// One byte to send, last releases chip select afterwards
	typedef struct packed {
		logic [7:0] tx;
		logic last;
	} spi_cmd_t;

	// Byte captured from miso during the transfer
	typedef struct packed {
		logic [7:0] rx;
	} spi_rsp_t;

	// Master sequencer states
	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_shift,
		st_release
	} master_state_t;

endpackage

//--- rtl/spi_sck_gen.sv
// SPI serial clock generator
// Divides the system clock into sck half periods while run is high
// and flags the cycle in which sck is about to rise or fall

`timescale 1ns/1ps

module spi_sck_gen (
	input  logic rvx_signal_03,
	input  logic csn,
	input  logic run,
	output logic sck,
	output logic rise,
	output logic fall
);

	import spi_pkg::*;

	// Half-period counter
	logic [sck_cnt_w-1:0] cnt;
	// High in the last cycle of a half period
	logic toggle;

	assign toggle = run && (cnt == sck_cnt_w'(sck_half - 1));

	// Edge strobes lead the sck register by one clock
	assign rise = toggle && !sck;
	assign fall = toggle && sck;

	always_ff @(posedge rvx_signal_03 or posedge csn)
	begin
		if (csn)
		begin
			cnt <= '0;
			sck <= 1'b0;
		end
		else if (!run)
		begin
			// Idle level for mode 0 is low
			cnt <= '0;
			sck <= 1'b0;
		end
		else if (toggle)
		begin
			cnt <= '0;
			sck <= ~sck;
		end
		else
		begin
			cnt <= cnt + 1'b1;
		end
	end

	// Edge strobes must be exclusive
	a_rise_fall_excl: assert property (@(posedge rvx_signal_03) disable iff (csn)
		!(rise && fall))
		else $error("sck_gen: rise and fall strobes high together");

endmodule

//--- rtl/spi_master.sv
// SPI mode-0 byte master
// Takes one byte command from the host, frames it with sel_n, shifts it
// out MSB first on mosi and returns the byte captured from miso.
// Chip select is held between bytes unless the command marks the last one

`timescale 1ns/1ps

module spi_master (
	input  logic              rvx_signal_03,
	input  logic              csn,
	input  logic              cmd_valid,
	input  spi_pkg::spi_cmd_t cmd,
	output logic              busy,
	output logic              rsp_valid,
	output spi_pkg::spi_rsp_t rsp,
	output logic              sck,
	output logic              sel_n,
	output logic              mosi,
	input  logic              miso
);

	import spi_pkg::*;

	master_state_t state;

	// sck generator handshake
	logic run;
	logic rise;
	logic fall;

	// Shift registers and bit count
	logic [7:0] tx_sr;
	logic [7:0] rx_sr;
	logic [2:0] bit_cnt;

	// Release chip select after this byte
	logic last_q;
	// Half period counter for the release phase
	logic [sck_cnt_w-1:0] rel_cnt;

	// Command accepted only from idle
	logic accept;
	// Eighth falling edge, byte complete
	logic byte_end;

	assign accept = cmd_valid && (state == st_idle);
	assign byte_end = (state == st_shift) && fall && (bit_cnt == 3'd0);

	// sck runs through the setup half period and the eight bit cells
	assign run = (state == st_setup) || (state == st_shift);
	assign busy = (state != st_idle);

	spi_sck_gen i_sck_gen (
		.rvx_signal_03 (rvx_signal_03),
		.csn           (csn),
		.run           (run),
		.sck           (sck),
		.rise          (rise),
		.fall          (fall)
	);

	// ************************************************************
	// Sequencer
	// ************************************************************

	always_ff @(posedge rvx_signal_03 or posedge csn)
	begin
		if (csn)
		begin
			state <= st_idle;
			sel_n <= 1'b1;
			mosi <= 1'b0;
			bit_cnt <= 3'd7;
			last_q <= 1'b0;
			rel_cnt <= '0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			rsp_valid <= 1'b0;
			case (state)
				st_idle:
				begin
					if (accept)
					begin
						// Select and present the MSB while sck is idle
						state <= st_setup;
						sel_n <= 1'b0;
						mosi <= cmd.tx[7];
						bit_cnt <= 3'd7;
						last_q <= cmd.last;
					end
				end
				st_setup:
				begin
					// First rising edge ends the setup half period
					if (rise)
						state <= st_shift;
				end
				st_shift:
				begin
					if (byte_end)
					begin
						mosi <= 1'b0;
						rel_cnt <= '0;
						if (last_q)
							state <= st_release;
						else
						begin
							// sel_n stays low for the next byte
							state <= st_idle;
							rsp_valid <= 1'b1;
						end
					end
					else if (fall)
					begin
						mosi <= tx_sr[7];
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				st_release:
				begin
					// Deselect one clock after sck has settled low
					sel_n <= 1'b1;
					if (rel_cnt == sck_cnt_w'(sck_half - 1))
					begin
						state <= st_idle;
						rsp_valid <= 1'b1;
					end
					else
						rel_cnt <= rel_cnt + 1'b1;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// ************************************************************
	// Data path
	// ************************************************************

	always_ff @(posedge rvx_signal_03)
	begin
		// Remaining bits queue behind the MSB already on mosi
		if (accept)
			tx_sr <= {cmd.tx[6:0], 1'b0};
		else if (fall && !byte_end)
			tx_sr <= {tx_sr[6:0], 1'b0};
		// miso sampled on each rising edge
		if (rise)
			rx_sr <= {rx_sr[6:0], miso};
		if (byte_end)
			rsp.rx <= rx_sr;
	end

	// Host must wait for busy low before issuing a command
	a_cmd_not_busy: assert property (@(posedge rvx_signal_03) disable iff (csn)
		cmd_valid |-> !busy)
		else $error("spi_master: cmd_valid while busy");

	// Clock pulses only inside a selected frame
	a_sck_selected: assert property (@(posedge rvx_signal_03) disable iff (csn)
		sck |-> !sel_n)
		else $error("spi_master: sck high while deselected");

endmodule

//--- rtl/spi_slave_buffer.sv
// SPI mode-0 exchange buffer slave
// Eight-byte buffer behind a wrapping pointer. Each received byte is
// answered with the byte stored at the pointer, then written in its
// place. All SPI inputs are resynchronized to the system clock

`timescale 1ns/1ps

module spi_slave_buffer (
	input  logic rvx_signal_03,
	input  logic csn,
	input  logic sck,
	input  logic sel_n,
	input  logic mosi,
	output logic miso
);

	import spi_pkg::*;

	// ************************************************************
	// Input synchronizers
	// ************************************************************

	// Two sync stages plus one history stage for edge detection
	logic [2:0] sck_sync;
	logic [1:0] sel_sync;
	logic [1:0] mosi_sync;

	logic sck_rise;
	logic sck_fall;
	logic sel_s;
	logic mosi_s;

	always_ff @(posedge rvx_signal_03 or posedge csn)
	begin
		if (csn)
		begin
			sck_sync <= 3'b000;
			sel_sync <= 2'b11;
			mosi_sync <= 2'b00;
		end
		else
		begin
			sck_sync <= {sck_sync[1:0], sck};
			sel_sync <= {sel_sync[0], sel_n};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	// Same depth on all three, so mosi stays aligned with sck
	assign sel_s = sel_sync[1];
	assign mosi_s = mosi_sync[1];
	assign sck_rise = sck_sync[1] && !sck_sync[2];
	assign sck_fall = !sck_sync[1] && sck_sync[2];

	// ************************************************************
	// Bit framing
	// ************************************************************

	// Buffer storage and pointer
	logic [buf_depth-1:0][7:0] mem;
	logic [ptr_w-1:0] ptr;

	logic [7:0] rx_sr;
	logic [7:0] out_sr;
	// Counts down from 7, zero marks the eighth rising edge
	logic [2:0] bit_cnt;
	// Delay line for the write strobe
	logic [2:0] wr_pipe;
	logic wr_strobe;

	always_ff @(posedge rvx_signal_03 or posedge csn)
	begin
		if (csn)
			bit_cnt <= 3'd7;
		else if (sel_s)
			bit_cnt <= 3'd7;
		else if (sck_rise)
			bit_cnt <= bit_cnt - 1'b1;
	end

	// Write lands three cycles after the eighth rising edge,
	// ahead of the falling edge that reloads the output register
	always_ff @(posedge rvx_signal_03 or posedge csn)
	begin
		if (csn)
			wr_pipe <= 3'b000;
		else
			wr_pipe <= {wr_pipe[1:0], sck_rise && !sel_s && (bit_cnt == 3'd0)};
	end

	assign wr_strobe = wr_pipe[2];

	// Receive side, MSB first
	always_ff @(posedge rvx_signal_03)
	begin
		if (sck_rise)
			rx_sr <= {rx_sr[6:0], mosi_s};
	end

	// Transmit side
	always_ff @(posedge rvx_signal_03)
	begin
		// Track the pointer entry while idle, so the frame starts loaded
		if (sel_s)
			out_sr <= mem[ptr];
		// Byte boundary, counter has wrapped back to 7
		else if (sck_fall && (bit_cnt == 3'd7))
			out_sr <= mem[ptr];
		else if (sck_fall)
			out_sr <= {out_sr[6:0], 1'b0};
	end

	// Quiet low when deselected, no tri-state on chip
	assign miso = !sel_s && out_sr[7];

	// ************************************************************
	// Buffer and pointer
	// ************************************************************

	always_ff @(posedge rvx_signal_03 or posedge csn)
	begin
		if (csn)
		begin
			mem <= buf_init;
			ptr <= '0;
		end
		else if (wr_strobe)
		begin
			mem[ptr] <= rx_sr;
			// Wraps naturally at buf_depth
			ptr <= ptr + 1'b1;
		end
	end

	// Master only toggles sck inside a frame, as seen after sync
	a_no_edge_deselected: assert property (@(posedge rvx_signal_03) disable iff (csn)
		(sck_rise || sck_fall) |-> !sel_s)
		else $error("spi_slave_buffer: sck edge while deselected");

	// Pointer moves one step at a time
	a_ptr_step: assert property (@(posedge rvx_signal_03) disable iff (csn)
		(ptr != $past(ptr)) |-> (ptr == ptr_w'($past(ptr) + 1'b1)))
		else $error("spi_slave_buffer: pointer jumped");

endmodule

//--- rtl/spi_top.sv
// SPI subsystem top
// Byte master driven by host strobes, wired on chip to the
// eight-byte exchange buffer slave

`timescale 1ns/1ps

module spi_top (
	input  logic              rvx_signal_03,
	input  logic              csn,
	input  logic              cmd_valid,
	input  spi_pkg::spi_cmd_t cmd,
	output logic              busy,
	output logic              rsp_valid,
	output spi_pkg::spi_rsp_t rsp
);

	// SPI wires between master and slave
	logic sck;
	logic sel_n;
	logic mosi;
	logic miso;

	spi_master i_master (
		.rvx_signal_03 (rvx_signal_03),
		.csn           (csn),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.busy          (busy),
		.rsp_valid     (rsp_valid),
		.rsp           (rsp),
		.sck           (sck),
		.sel_n         (sel_n),
		.mosi          (mosi),
		.miso          (miso)
	);

	spi_slave_buffer i_slave (
		.rvx_signal_03 (rvx_signal_03),
		.csn           (csn),
		.sck           (sck),
		.sel_n         (sel_n),
		.mosi          (mosi),
		.miso          (miso)
	);

endmodule

//--- verification/spi_tb.sv
// SPI subsystem testbench
// Sends random byte commands through the master to the exchange buffer
// slave. Assertions check the host handshake and every returned byte
// against a model of the eight-byte buffer

`timescale 1ns/1ps

module spi_tb;

	import spi_pkg::*;

	// Clocks allowed for any single wait
	localparam int wait_limit = 400;
	// Reset pulse length in clocks
	localparam int reset_cycles = 16;

	logic rvx_signal_03;
	logic csn;
	logic cmd_valid;
	spi_cmd_t cmd;
	logic busy;
	logic rsp_valid;
	spi_rsp_t rsp;

	// Random stimulus
	integer seed;
	logic [31:0] rnd;

	// Buffer model, its pointer and the byte due next
	logic [buf_depth-1:0][7:0] model;
	logic [ptr_w-1:0] p;
	logic [7:0] exp_rx;

	// Command outstanding between accept and response
	logic pending;
	// Response count since the last reset saturates at 8
	logic [3:0] rsp_since_reset;
	int cmd_count;
	int rsp_count;

	spi_top i_dut (
		.rvx_signal_03 (rvx_signal_03),
		.csn           (csn),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.busy          (busy),
		.rsp_valid     (rsp_valid),
		.rsp           (rsp)
	);

	// 4 ns system clock
	initial
	begin
		rvx_signal_03 = 1'b0;
		forever
			#2 rvx_signal_03 = ~rvx_signal_03;
	end

	// ************************************************************
	// Helpers
	// ************************************************************

	// Print the error, then the fail message, then stop
	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	// Byte at entry idx of the power-up image counting up from 0x11
	function automatic logic [7:0] power_up_byte(input logic [3:0] idx);
		logic [3:0] n;
		n = idx + 4'd1;
		return {n, n};
	endfunction

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && (n < wait_limit))
		begin
			@(posedge rvx_signal_03);
			n++;
		end
		if (busy)
			stop_run("Timed out waiting for busy to go low");
	endtask

	task automatic wait_response();
		int n;
		n = 0;
		while (!rsp_valid && (n < wait_limit))
		begin
			@(posedge rvx_signal_03);
			n++;
		end
		if (!rsp_valid)
			stop_run("Timed out waiting for rsp_valid");
	endtask

	// One command, one strobe cycle, then the response
	task automatic send_byte(input logic [7:0] byte_tx, input logic byte_last);
		wait_idle();
		// Answer is the byte now at the pointer, which tx then replaces
		exp_rx <= model[p];
		model[p] = byte_tx;
		p = p + ptr_w'(1);
		cmd_valid <= 1'b1;
		cmd.tx <= byte_tx;
		cmd.last <= byte_last;
		cmd_count++;
		@(posedge rvx_signal_03);
		cmd_valid <= 1'b0;
		wait_response();
	endtask

	task automatic send_random(input int count, input logic allow_last);
		logic end_frame;
		for (int i = 0; i < count; i++)
		begin
			rnd = $random(seed);
			// Roughly one in four closes the frame and so does every sixth
			end_frame = allow_last && ((rnd[9:8] == 2'b00) || (i % 6 == 5));
			send_byte(rnd[7:0], end_frame);
		end
	endtask

	task automatic apply_reset();
		csn <= 1'b1;
		repeat (reset_cycles) @(posedge rvx_signal_03);
		csn <= 1'b0;
		// Model back to the power-up image
		model = buf_init;
		p = '0;
	endtask

	// ************************************************************
	// Bookkeeping and checks
	// ************************************************************

	always_ff @(posedge rvx_signal_03 or posedge csn)
	begin
		if (csn)
		begin
			pending <= 1'b0;
			rsp_since_reset <= 4'd0;
		end
		else
		begin
			if (cmd_valid && !busy)
				pending <= 1'b1;
			else if (rsp_valid)
				pending <= 1'b0;
			if (rsp_valid && (rsp_since_reset != 4'd8))
				rsp_since_reset <= rsp_since_reset + 4'd1;
		end
	end

	always_ff @(posedge rvx_signal_03)
	begin
		if (rsp_valid)
			rsp_count <= rsp_count + 1;
	end

	a_reset_quiet: assert property (@(posedge rvx_signal_03)
		csn |-> (!busy && !rsp_valid))
		else stop_run($sformatf("Fail at %0t: busy or rsp_valid high in reset", $time));

	// No activity without an accepted command
	a_busy_owned: assert property (@(posedge rvx_signal_03) disable iff (csn)
		busy |-> pending)
		else stop_run($sformatf("Fail at %0t: busy without a command", $time));
	a_rsp_owned: assert property (@(posedge rvx_signal_03) disable iff (csn)
		rsp_valid |-> pending)
		else stop_run($sformatf("Fail at %0t: response without a command", $time));

	a_busy_rise: assert property (@(posedge rvx_signal_03) disable iff (csn)
		(cmd_valid && !busy) |=> busy)
		else stop_run($sformatf("Fail at %0t: busy did not rise after accept", $time));
	// busy drops together with the single response pulse
	a_busy_fall: assert property (@(posedge rvx_signal_03) disable iff (csn)
		$fell(busy) |-> rsp_valid)
		else stop_run($sformatf("Fail at %0t: busy fell without rsp_valid", $time));
	a_rsp_not_busy: assert property (@(posedge rvx_signal_03) disable iff (csn)
		rsp_valid |-> !busy)
		else stop_run($sformatf("Fail at %0t: rsp_valid while busy", $time));
	a_rsp_pulse: assert property (@(posedge rvx_signal_03) disable iff (csn)
		rsp_valid |=> !rsp_valid)
		else stop_run($sformatf("Fail at %0t: rsp_valid longer than a cycle", $time));

	a_rsp_value: assert property (@(posedge rvx_signal_03) disable iff (csn)
		rsp_valid |-> (rsp.rx == exp_rx))
		else stop_run($sformatf("Fail at %0t: rx %02h, expected %02h",
			$time, rsp.rx, exp_rx));
	// First pass after any reset reads the power-up image
	a_power_up: assert property (@(posedge rvx_signal_03) disable iff (csn)
		(rsp_valid && (rsp_since_reset < 4'd8)) |->
			(rsp.rx == power_up_byte(rsp_since_reset)))
		else stop_run($sformatf("Fail at %0t: rx %02h, power-up byte %02h",
			$time, rsp.rx, power_up_byte(rsp_since_reset)));

	// ************************************************************
	// Stimulus
	// ************************************************************

	initial
	begin
		seed = 32'heab58b92;
		csn = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		model = buf_init;
		p = '0;
		exp_rx = '0;
		apply_reset();
		// Nothing may move in the idle gap before the first command
		repeat (10) @(posedge rvx_signal_03);
		// Power-up image with the frame held open
		send_random(8, 1'b0);
		// Two more passes with pointer wrap and frames closed at random
		send_random(24, 1'b1);
		// Last response and its pulse check complete before reset
		repeat (2) @(posedge rvx_signal_03);
		// Reset between transfers while sel_n may still be low
		apply_reset();
		repeat (4) @(posedge rvx_signal_03);
		send_random(8, 1'b1);
		wait_idle();
		repeat (8) @(posedge rvx_signal_03);
		if (rsp_count != cmd_count)
			stop_run("Number of responses differs from number of commands");
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

//--- project.f
rtl/spi_pkg.sv
rtl/spi_sck_gen.sv
rtl/spi_master.sv
rtl/spi_slave_buffer.sv
rtl/spi_top.sv
verification/spi_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the SPI subsystem testbench with Verilator and run it.
# The exit status is the simulator's status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module spi_tb \
	-f project.f \
	-o spi_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

if [ ! -x ./obj_dir/spi_sim ]; then
	echo "Simulation binary not found"
	exit 1
fi

./obj_dir/spi_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
fi
exit "$status"
